//--- all.f
hw/spidergon_pkg.sv
hw/flit_pkg.sv
hw/input_port.sv
hw/output_arbiter.sv
hw/spidergon_node.sv
hw/spidergon_top.sv
sim/tb_spidergon.sv

//--- hw/flit_pkg.sv
// flit and link formats carried between router nodes and at the injection/ejection ports
package flit_pkg;

	typedef logic [9:0] payload_t;

	// a packet is a single flit
	typedef struct packed
	{
		spidergon_pkg::node_id_t dest;
		spidergon_pkg::node_id_t src;
		payload_t                payload;
	} flit_t;

	// valid qualifies the flit for one cycle
	typedef struct packed
	{
		logic  valid;
		flit_t flit;
	} link_t;

	// entries in each input queue
	localparam int buffer_depth = 2;

endpackage

//--- hw/input_port.sv
// input queue of a router node; buffers arriving flits and presents the head with its route
`timescale 1ns/1ps

module input_port
#(
	parameter spidergon_pkg::node_id_t node_id = '0
)
(
	input  logic                     clk,
	input  logic                     reset,
	input  flit_pkg::link_t          in,
	output logic                     full,
	input  logic                     pop,
	output flit_pkg::flit_t          head,
	output logic                     head_valid,
	output spidergon_pkg::port_dir_t head_dir
);

	localparam int ptr_w = $clog2(flit_pkg::buffer_depth);
	localparam int cnt_w = $clog2(flit_pkg::buffer_depth + 1);

	flit_pkg::flit_t mem [flit_pkg::buffer_depth];
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w-1:0] wr_ptr;
	logic [cnt_w-1:0] count;
	logic [cnt_w-1:0] count_next;
	logic do_write;
	logic do_pop;

	// circular pointer step
	function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
		if (ptr == ptr_w'(flit_pkg::buffer_depth - 1))
		begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// on/off flow control, upstream never sends while full is high
	assign do_write = in.valid && !full;
	assign do_pop = pop && head_valid;

	always_comb
	begin
		count_next = count;
		case ({do_write, do_pop})
			2'b10: count_next = count + 1'b1;
			2'b01: count_next = count - 1'b1;
			default: count_next = count;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
			full <= 1'b0;
		end
		else
		begin
			if (do_write)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			count <= count_next;
			// registered level tracks the occupancy after this edge
			full <= (count_next == cnt_w'(flit_pkg::buffer_depth));
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_write)
			mem[wr_ptr] <= in.flit;
	end

	assign head = mem[rd_ptr];
	assign head_valid = (count != '0);
	assign head_dir = spidergon_pkg::route_dir(node_id, head.dest);

endmodule

//--- hw/output_arbiter.sv
// round-robin arbiter that picks one input port per cycle for a single node output
`timescale 1ns/1ps

module output_arbiter
(
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic [spidergon_pkg::num_ports-1:0]  request,
	output logic [spidergon_pkg::num_ports-1:0]  grant
);

	localparam int num_ports = spidergon_pkg::num_ports;
	localparam int sel_w = $clog2(num_ports);

	logic [sel_w-1:0] ptr;
	logic [sel_w-1:0] idx;
	logic [sel_w-1:0] winner;
	logic found;

	// search starts at the priority pointer and wraps
	always_comb
	begin
		grant = '0;
		winner = ptr;
		found = 1'b0;
		idx = ptr;
		for (int i = 0; i < num_ports; i++)
		begin
			idx = ptr + sel_w'(i);
			if (!found && request[idx])
			begin
				found = 1'b1;
				winner = idx;
			end
		end
		if (found)
			grant[winner] = 1'b1;
	end

	// the winner drops to lowest priority for the next round
	always_ff @(posedge clk)
	begin
		if (reset)
			ptr <= '0;
		else if (found)
			ptr <= winner + 1'b1;
	end

endmodule

//--- hw/spidergon_node.sv
// one spidergon router: four input queues, per-output arbitration and the crossbar between them
`timescale 1ns/1ps

module spidergon_node
#(
	parameter spidergon_pkg::node_id_t node_id = '0
)
(
	input  logic                  clk,
	input  logic                  reset,
	input  flit_pkg::link_t [2:0] link_in,
	output logic [2:0]            link_in_full,
	output flit_pkg::link_t [2:0] link_out,
	input  logic [2:0]            link_out_full,
	input  flit_pkg::link_t       inject,
	output logic                  inject_full,
	output flit_pkg::link_t       eject
);

	localparam int num_ports = spidergon_pkg::num_ports;

	flit_pkg::link_t [num_ports-1:0] port_in;
	flit_pkg::link_t [num_ports-1:0] port_out;
	logic [num_ports-1:0] port_full;
	logic [num_ports-1:0] out_blocked;
	logic [num_ports-1:0] head_valid;
	logic [num_ports-1:0] pop;
	logic [num_ports-1:0][num_ports-1:0] request;
	logic [num_ports-1:0][num_ports-1:0] grant;
	flit_pkg::flit_t head [num_ports];
	spidergon_pkg::port_dir_t head_dir [num_ports];

	// local port takes the top index, matching dir_local
	assign port_in = {inject, link_in};
	assign link_in_full = port_full[2:0];
	assign inject_full = port_full[spidergon_pkg::dir_local];

	// ejection never back-pressures
	assign out_blocked = {1'b0, link_out_full};

	for (genvar i = 0; i < num_ports; i++)
	begin : g_in
		input_port
		#(
			.node_id(node_id)
		)
		u_port
		(
			.clk(clk),
			.reset(reset),
			.in(port_in[i]),
			.full(port_full[i]),
			.pop(pop[i]),
			.head(head[i]),
			.head_valid(head_valid[i]),
			.head_dir(head_dir[i])
		);
	end

	// route decode, held back while the next queue is full
	always_comb
	begin
		for (int o = 0; o < num_ports; o++)
		begin
			for (int i = 0; i < num_ports; i++)
			begin
				request[o][i] = head_valid[i] && !out_blocked[o]
					&& (head_dir[i] == spidergon_pkg::port_dir_t'(o));
			end
		end
	end

	for (genvar o = 0; o < num_ports; o++)
	begin : g_out
		output_arbiter u_arb
		(
			.clk(clk),
			.reset(reset),
			.request(request[o]),
			.grant(grant[o])
		);
	end

	// each head routes to exactly one output, so at most one grant per input
	always_comb
	begin
		pop = '0;
		for (int o = 0; o < num_ports; o++)
			pop = pop | grant[o];
	end

	// crossbar
	always_comb
	begin
		for (int o = 0; o < num_ports; o++)
		begin
			port_out[o].valid = |grant[o];
			port_out[o].flit = '0;
			for (int i = 0; i < num_ports; i++)
			begin
				if (grant[o][i])
					port_out[o].flit = head[i];
			end
		end
	end

	assign link_out = port_out[2:0];
	assign eject = port_out[spidergon_pkg::dir_local];

endmodule

//--- hw/spidergon_pkg.sv
// spidergon topology definitions shared by the router RTL and the testbench reference model
package spidergon_pkg;

	// eight nodes on a bidirectional ring with across links
	localparam int num_nodes = 8;

	// offsets up to this distance stay on the ring
	localparam int quarter_ring = 2;

	// three link ports plus the local injection/ejection port
	localparam int num_ports = 4;

	typedef logic [$clog2(num_nodes)-1:0] node_id_t;

	// indexes both input and output ports of a node
	typedef enum logic [1:0]
	{
		dir_anticlockwise = 2'd0,
		dir_clockwise     = 2'd1,
		dir_across        = 2'd2,
		dir_local         = 2'd3
	} port_dir_t;

	// deterministic route from the relative offset, taken modulo the ring size
	function automatic port_dir_t route_dir(input node_id_t current, input node_id_t dest);
		node_id_t offset;
		offset = dest - current;
		if (offset == '0)
		begin
			return dir_local;
		end
		if (offset <= quarter_ring)
		begin
			return dir_clockwise;
		end
		if (offset >= num_nodes - quarter_ring)
		begin
			return dir_anticlockwise;
		end
		// remaining offsets are cheaper via the node opposite
		return dir_across;
	endfunction

endpackage

//--- hw/spidergon_top.sv
// eight-node spidergon network; ring and across links between nodes, per-node inject and eject
`timescale 1ns/1ps

module spidergon_top
(
	input  logic                                           clk,
	input  logic                                           reset,
	input  flit_pkg::link_t [spidergon_pkg::num_nodes-1:0] inject,
	output logic [spidergon_pkg::num_nodes-1:0]            inject_full,
	output flit_pkg::link_t [spidergon_pkg::num_nodes-1:0] eject
);

	localparam int num_nodes = spidergon_pkg::num_nodes;

	localparam spidergon_pkg::port_dir_t acw = spidergon_pkg::dir_anticlockwise;
	localparam spidergon_pkg::port_dir_t cw = spidergon_pkg::dir_clockwise;
	localparam spidergon_pkg::port_dir_t acr = spidergon_pkg::dir_across;

	flit_pkg::link_t [2:0] link_in [num_nodes];
	flit_pkg::link_t [2:0] link_out [num_nodes];
	logic [2:0] in_full [num_nodes];
	logic [2:0] out_full [num_nodes];

	for (genvar n = 0; n < num_nodes; n++)
	begin : g_node
		// neighbours with wrap-around
		localparam int nxt = (n + 1) % num_nodes;
		localparam int prv = (n + num_nodes - 1) % num_nodes;
		localparam int opp = (n + num_nodes / 2) % num_nodes;

		// clockwise traffic from the previous node arrives on the anticlockwise input
		assign link_in[n][acw] = link_out[prv][cw];
		assign link_in[n][cw] = link_out[nxt][acw];
		assign link_in[n][acr] = link_out[opp][acr];

		// full levels run against the flit direction
		assign out_full[n][cw] = in_full[nxt][acw];
		assign out_full[n][acw] = in_full[prv][cw];
		assign out_full[n][acr] = in_full[opp][acr];

		spidergon_node
		#(
			.node_id(spidergon_pkg::node_id_t'(n))
		)
		u_node
		(
			.clk(clk),
			.reset(reset),
			.link_in(link_in[n]),
			.link_in_full(in_full[n]),
			.link_out(link_out[n]),
			.link_out_full(out_full[n]),
			.inject(inject[n]),
			.inject_full(inject_full[n]),
			.eject(eject[n])
		);
	end

endmodule

//--- sim/tb_spidergon.sv
// self-checking testbench for the spidergon network; run with spidergon_top from the file list
`timescale 1ns/1ps

module tb_spidergon;

	localparam int num_nodes = spidergon_pkg::num_nodes;
	localparam int random_packets = 300;
	localparam int max_in_flight = 8;
	localparam int stream_cycles = 200;
	localparam int total_packets = num_nodes * num_nodes + num_nodes + random_packets
		+ 3 * stream_cycles;
	localparam int watchdog_cycles = total_packets * 60 + 2000;

	logic clk = 1'b0;
	logic reset;
	flit_pkg::link_t [num_nodes-1:0] inject;
	logic [num_nodes-1:0] inject_full;
	flit_pkg::link_t [num_nodes-1:0] eject;

	// one FIFO of expected flits per source and destination pair
	flit_pkg::flit_t expected_q [num_nodes * num_nodes][$];
	logic [num_nodes-1:0] full_seen;
	int in_flight;
	logic [31:0] rng_state;
	logic seen_full;
	int sent;
	int stream_src [3] = '{0, 3, 5};
	flit_pkg::flit_t exp_flit;
	int pair;

	spidergon_top uut
	(
		.clk(clk),
		.reset(reset),
		.inject(inject),
		.inject_full(inject_full),
		.eject(eject)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// a flit leaves the network at its destination
	function automatic int expected_node(input flit_pkg::flit_t f);
		return int'(f.dest);
	endfunction

	// first hop by the offset rule with 0 anticlockwise, 1 clockwise, 2 across and 3 local
	function automatic int expected_dir(input int src, input int dest);
		int offset;
		offset = (dest - src + num_nodes) % num_nodes;
		if (offset == 0)
			return 3;
		if (offset <= 2)
			return 1;
		if (offset >= 6)
			return 0;
		return 2;
	endfunction

	function automatic int pair_index(input int src, input int dest);
		return src * num_nodes + dest;
	endfunction

	function automatic int pending_offers();
		int n;
		n = 0;
		for (int s = 0; s < num_nodes; s++)
			n += inject[s].valid;
		return n;
	endfunction

	task automatic compare_values(input string name, input int expected, input int actual);
		if (expected != actual)
		begin
			$display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic stop_with_error(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1);
	endtask

	// at the falling edge retire offers taken on the last rising edge and sample full
	task automatic tick();
		int idx;
		@(negedge clk);
		for (int s = 0; s < num_nodes; s++)
		begin
			if (inject[s].valid && !full_seen[s])
			begin
				idx = pair_index(int'(inject[s].flit.src), int'(inject[s].flit.dest));
				expected_q[idx].push_back(inject[s].flit);
				in_flight++;
				inject[s].valid = 1'b0;
			end
			// full cannot change before the next rising edge
			full_seen[s] = inject_full[s];
		end
	endtask

	// held on the port until the node takes it
	task automatic offer(input int src, input int dest, input logic [31:0] r);
		inject[src].valid = 1'b1;
		inject[src].flit.dest = spidergon_pkg::node_id_t'(dest);
		inject[src].flit.src = spidergon_pkg::node_id_t'(src);
		inject[src].flit.payload = r[9:0];
	endtask

	task automatic wait_drain();
		while (in_flight != 0 || pending_offers() != 0)
			tick();
	endtask

	// every ejection is matched against the head of its pair FIFO
	always @(posedge clk)
	begin
		if (!reset)
		begin
			for (int k = 0; k < num_nodes; k++)
			begin
				if (eject[k].valid)
				begin
					pair = pair_index(int'(eject[k].flit.src), int'(eject[k].flit.dest));
					if (expected_q[pair].size() == 0)
						stop_with_error($sformatf(
							"unexpected packet from node %0d to node %0d ejected at node %0d",
							eject[k].flit.src, eject[k].flit.dest, k));
					exp_flit = expected_q[pair].pop_front();
					in_flight--;
					compare_values("ejecting node", expected_node(exp_flit), k);
					compare_values("payload", int'(exp_flit.payload),
						int'(eject[k].flit.payload));
				end
			end
		end
	end

	initial
	begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout: packets were not delivered within %0d cycles", watchdog_cycles);
		$display("Test failed");
		$fatal(1);
	end

	initial
	begin
		reset = 1'b1;
		inject = '0;
		full_seen = '0;
		in_flight = 0;
		seen_full = 1'b0;
		sent = 0;
		rng_state = 32'h26c42db7;
		repeat (16) @(negedge clk);
		reset = 1'b0;

		// idle network after reset
		for (int n = 0; n < num_nodes; n++)
		begin
			compare_values("reset eject valid", 0, int'(eject[n].valid));
			compare_values("reset inject_full", 0, int'(inject_full[n]));
		end

		// every pair with one packet at a time
		for (int s = 0; s < num_nodes; s++)
		begin
			for (int d = 0; d < num_nodes; d++)
			begin
				compare_values("first hop direction", expected_dir(s, d),
					int'(spidergon_pkg::route_dir(spidergon_pkg::node_id_t'(s),
					spidergon_pkg::node_id_t'(d))));
				tick();
				offer(s, d, next_random());
				wait_drain();
			end
		end

		// self-addressed packet ejects in the cycle after acceptance
		for (int n = 0; n < num_nodes; n++)
		begin
			tick();
			offer(n, n, next_random());
			tick();
			compare_values("self eject valid", 1, int'(eject[n].valid));
			compare_values("self eject source", n, int'(eject[n].flit.src));
			wait_drain();
		end

		// random traffic with the in-flight count kept below the ring buffer capacity
		while (sent < random_packets)
		begin
			tick();
			for (int s = 0; s < num_nodes; s++)
			begin
				if (!inject[s].valid && sent < random_packets
					&& in_flight + pending_offers() < max_in_flight)
				begin
					rng_state = next_random();
					if (rng_state[31])
					begin
						offer(s, int'(rng_state[30:28]), rng_state >> 18);
						sent++;
					end
				end
			end
		end
		wait_drain();

		// nodes 0, 3 and 5 all stream to node 4 to force back-pressure
		for (int c = 0; c < stream_cycles; c++)
		begin
			tick();
			if (inject_full[0])
				seen_full = 1'b1;
			for (int k = 0; k < 3; k++)
			begin
				if (!inject[stream_src[k]].valid)
					offer(stream_src[k], 4, next_random());
			end
		end
		wait_drain();
		compare_values("node 0 inject_full under load", 1, int'(seen_full));

		// late duplicates would show up here
		repeat (20) tick();
		$display("Test passed");
		$finish;
	end

endmodule
